// File: flist.f
hdl/issue_pkg.sv
hdl/instr_decoder.sv
hdl/instr_issue.sv
hdl/pipe_tracker.sv
hdl/issue_top.sv
dv/issue_assert.sv
dv/tb_issue_top.sv

// File: Bender.yml
package:
  name: issue_front

sources:
  - hdl/issue_pkg.sv
  - hdl/instr_decoder.sv
  - hdl/instr_issue.sv
  - hdl/pipe_tracker.sv
  - hdl/issue_top.sv
  - target: test
    files:
      - dv/issue_assert.sv
      - dv/tb_issue_top.sv

// File: dv/issue_cases.txt
# grp valid instr0 instr1 dsne | expected: issue_num stall_req op0 op1
# hex fields, one line per clock after reset, grp is the behavior number
5 3 00221821 00853021 0 2 0 1 1
5 3 00853021 00221821 0 2 0 1 1
1 3 00221821 00613821 0 1 0 1 0
1 3 ac850000 ac880000 0 1 0 3 0
1 3 00220018 00005012 0 1 0 5 0
1 3 00221821 e08b0000 0 1 0 1 0
1 3 00853021 0085001a 0 1 0 1 0
1 3 00221821 10220004 0 1 0 1 0
1 3 00221821 00000040 0 1 0 1 0
2 3 8c280000 00853021 0 2 0 2 1
2 3 01023821 00853021 0 2 1 1 1
2 3 01023821 00853021 0 2 1 1 1
2 3 01023821 00853021 0 2 1 1 1
2 3 01023821 00853021 0 2 0 1 1
2 3 8c490000 00221821 0 2 0 2 1
2 3 00853021 00221821 0 2 0 1 1
2 3 00221821 00853021 0 2 0 1 1
2 3 ac890000 00853021 0 2 0 3 1
3 3 400c6000 00221821 0 1 0 9 0
3 3 00221821 00853021 0 2 1 1 1
3 3 00221821 00853021 0 2 1 1 1
3 3 00221821 00853021 0 2 1 1 1
3 3 00221821 00853021 0 2 1 1 1
3 3 00221821 00853021 0 2 0 1 1
4 1 10220004 00000000 0 1 1 4 0
4 3 10220004 00853021 0 2 0 4 1
4 3 00221821 00853021 1 1 0 1 0
4 0 00000000 00000000 0 1 1 0 0

// File: dv/tb_issue_top.sv
`default_nettype none

module tb_issue_top import issue_pkg::*; ();

	localparam int DEPTH        = 3;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_CASES    = 64;
	localparam int CNT_W        = $clog2(ISSUE_NUM + 1);

	logic                 clk = 1'b0;
	logic                 arst_n;
	logic [ISSUE_NUM-1:0] fetch_valid;
	logic [31:0]          fetch_instr0;
	logic [31:0]          fetch_instr1;
	logic                 delayslot_not_exec;
	logic [CNT_W-1:0]     issue_num;
	logic                 stall_req;
	op_t                  issue_op0;
	op_t                  issue_op1;

	// case table from the data file
	int                   c_grp [MAX_CASES];
	logic [ISSUE_NUM-1:0] c_valid [MAX_CASES];
	logic [31:0]          c_instr0 [MAX_CASES];
	logic [31:0]          c_instr1 [MAX_CASES];
	logic                 c_dsne [MAX_CASES];
	logic [CNT_W-1:0]     c_num [MAX_CASES];
	logic                 c_stall [MAX_CASES];
	op_t                  c_op0 [MAX_CASES];
	op_t                  c_op1 [MAX_CASES];

	int n_cases     = 0;
	int n_checks    = 0;
	int n_errors    = 0;
	int cycles      = 0;
	int cycle_limit = RESET_CYCLES + 20;

	issue_top #(
		.DCACHE_PIPE_DEPTH (DEPTH)
	) u_issue_top (
		.clk                (clk),
		.arst_n             (arst_n),
		.fetch_valid        (fetch_valid),
		.fetch_instr0       (fetch_instr0),
		.fetch_instr1       (fetch_instr1),
		.delayslot_not_exec (delayslot_not_exec),
		.issue_num          (issue_num),
		.stall_req          (stall_req),
		.issue_op0          (issue_op0),
		.issue_op1          (issue_op1)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, the case sequence did not finish", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic read_cases();
		int          fd;
		int          n;
		string       line;
		int          g;
		logic [31:0] v, i0, i1, d, num, st, o0, o1;
		fd = $fopen("dv/issue_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open dv/issue_cases.txt");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			// blank lines and column notes
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			n = $sscanf(line, "%d %h %h %h %h %h %h %h %h", g, v, i0, i1, d, num, st, o0, o1);
			if (n != 9 || n_cases >= MAX_CASES) begin
				$display("malformed or surplus case line: %s", line);
				n_errors++;
			end else begin
				c_grp[n_cases]    = g;
				c_valid[n_cases]  = v[ISSUE_NUM-1:0];
				c_instr0[n_cases] = i0;
				c_instr1[n_cases] = i1;
				c_dsne[n_cases]   = d[0];
				c_num[n_cases]    = num[CNT_W-1:0];
				c_stall[n_cases]  = st[0];
				c_op0[n_cases]    = op_t'(o0[3:0]);
				c_op1[n_cases]    = op_t'(o1[3:0]);
				n_cases++;
			end
		end
		$fclose(fd);
	endtask

	task automatic check_num(input string name, input logic [CNT_W-1:0] exp,
		input logic [CNT_W-1:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_op(input string name, input op_t exp, input op_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s expected %s (%0d), got %s (%0d)",
				$time, name, exp.name(), exp, act.name(), act);
		end
	endtask

	task automatic report_group(input int grp, input int n_cyc, input int errs);
		$display("group %0d finished: %0d cycles, %0d errors", grp, n_cyc, errs);
	endtask

	initial begin
		int prev_grp;
		int grp_err_base;
		int grp_cycles;
		prev_grp           = -1;
		grp_err_base       = 0;
		grp_cycles         = 0;
		arst_n             = 1'b0;
		fetch_valid        = '0;
		fetch_instr0       = '0;
		fetch_instr1       = '0;
		delayslot_not_exec = 1'b0;
		read_cases();
		cycle_limit = n_cases + RESET_CYCLES + 20;
		if (n_cases == 0) begin
			$display("no case lines were read");
			n_errors++;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		for (int i = 0; i < n_cases; i++) begin
			@(posedge clk);
			fetch_valid        <= c_valid[i];
			fetch_instr0       <= c_instr0[i];
			fetch_instr1       <= c_instr1[i];
			delayslot_not_exec <= c_dsne[i];
			// outputs are combinational, settled by the falling edge
			@(negedge clk);
			if (c_grp[i] != prev_grp) begin
				if (prev_grp >= 0) begin
					report_group(prev_grp, grp_cycles, n_errors - grp_err_base);
				end
				prev_grp     = c_grp[i];
				grp_err_base = n_errors;
				grp_cycles   = 0;
			end
			grp_cycles++;
			check_num("issue_num", c_num[i], issue_num);
			check_bit("stall_req", c_stall[i], stall_req);
			check_op("issue_op0", c_op0[i], issue_op0);
			check_op("issue_op1", c_op1[i], issue_op1);
		end
		if (prev_grp >= 0) begin
			report_group(prev_grp, grp_cycles, n_errors - grp_err_base);
		end
		if (u_issue_top.u_issue_assert.fail_count != 0) begin
			$display("%0d assertion failures on the issue outputs",
				u_issue_top.u_issue_assert.fail_count);
			n_errors += u_issue_top.u_issue_assert.fail_count;
		end
		$display("%0d cases, %0d checks, %0d errors", n_cases, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/issue_assert.sv
`default_nettype none

module issue_assert import issue_pkg::*; (
	input logic                           clk,
	input logic                           arst_n,
	input logic [ISSUE_NUM-1:0]           fetch_valid,
	input logic [$clog2(ISSUE_NUM+1)-1:0] issue_num,
	input logic                           stall_req,
	input op_t                            issue_op1
);

	// failed assertion count
	int fail_count = 0;

	a_num_max: assert property (@(posedge clk) disable iff (!arst_n)
		issue_num <= ISSUE_NUM)
		else begin
			$error("issue count above the issue width");
			fail_count++;
		end

	// a dropped slot 1 must not leak its opcode
	a_op1_none: assert property (@(posedge clk) disable iff (!arst_n)
		issue_num < ISSUE_NUM |-> issue_op1 == OP_NONE)
		else begin
			$error("slot 1 opcode present on a single issue");
			fail_count++;
		end

	a_empty_stall: assert property (@(posedge clk) disable iff (!arst_n)
		fetch_valid == '0 |-> stall_req)
		else begin
			$error("empty fetch pair without stall");
			fail_count++;
		end

endmodule

bind issue_top issue_assert u_issue_assert (
	.clk         (clk),
	.arst_n      (arst_n),
	.fetch_valid (fetch_valid),
	.issue_num   (issue_num),
	.stall_req   (stall_req),
	.issue_op1   (issue_op1)
);

`default_nettype wire

// File: hdl/issue_top.sv
`default_nettype none

module issue_top import issue_pkg::*; #(
	parameter int DCACHE_PIPE_DEPTH = 3
) (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic [ISSUE_NUM-1:0]           fetch_valid,
	input  logic [31:0]                    fetch_instr0,
	input  logic [31:0]                    fetch_instr1,
	input  logic                           delayslot_not_exec,
	output logic [$clog2(ISSUE_NUM+1)-1:0] issue_num,
	output logic                           stall_req,
	output op_t                            issue_op0,
	output op_t                            issue_op1
);

	logic [REG_W-1:0] rs1_0;
	logic [REG_W-1:0] rs2_0;
	logic [REG_W-1:0] rd_0;
	op_t              op_0;
	logic             is_load_0;
	logic             is_store_0;
	logic             is_controlflow_0;
	logic             is_priv_0;
	logic             is_hilo_0;
	logic [REG_W-1:0] rs1_1;
	logic [REG_W-1:0] rs2_1;
	logic [REG_W-1:0] rd_1;
	op_t              op_1;
	logic             is_load_1;
	logic             is_store_1;
	logic             is_controlflow_1;
	logic             is_priv_1;
	logic             is_hilo_1;

	logic [ISSUE_NUM-1:0][REG_W-1:0]                        issue_rd;
	logic [ISSUE_NUM-1:0]                                   issue_is_load;
	logic [ISSUE_NUM-1:0]                                   issue_is_priv;
	logic [ISSUE_NUM-1:0][REG_W-1:0]                        ex_rd;
	logic [ISSUE_NUM-1:0]                                   ex_is_load;
	logic [ISSUE_NUM-1:0]                                   ex_is_priv;
	logic [DCACHE_PIPE_DEPTH-1:0][ISSUE_NUM-1:0][REG_W-1:0] dc_rd;
	logic [DCACHE_PIPE_DEPTH-1:0][ISSUE_NUM-1:0]            dc_is_load;
	logic [DCACHE_PIPE_DEPTH-1:0][ISSUE_NUM-1:0]            dc_is_priv;

	instr_decoder u_dec0 (
		.instr          (fetch_instr0),
		.valid          (fetch_valid[0]),
		.rs1            (rs1_0),
		.rs2            (rs2_0),
		.rd             (rd_0),
		.op             (op_0),
		.is_load        (is_load_0),
		.is_store       (is_store_0),
		.is_controlflow (is_controlflow_0),
		.is_priv        (is_priv_0),
		.is_hilo        (is_hilo_0)
	);

	instr_decoder u_dec1 (
		.instr          (fetch_instr1),
		.valid          (fetch_valid[1]),
		.rs1            (rs1_1),
		.rs2            (rs2_1),
		.rd             (rd_1),
		.op             (op_1),
		.is_load        (is_load_1),
		.is_store       (is_store_1),
		.is_controlflow (is_controlflow_1),
		.is_priv        (is_priv_1),
		.is_hilo        (is_hilo_1)
	);

	instr_issue #(
		.DCACHE_PIPE_DEPTH (DCACHE_PIPE_DEPTH)
	) u_issue (
		.fetch_valid        (fetch_valid),
		.rs1_0              (rs1_0),
		.rs2_0              (rs2_0),
		.rd_0               (rd_0),
		.op_0               (op_0),
		.is_load_0          (is_load_0),
		.is_store_0         (is_store_0),
		.is_controlflow_0   (is_controlflow_0),
		.is_priv_0          (is_priv_0),
		.is_hilo_0          (is_hilo_0),
		.rs1_1              (rs1_1),
		.rs2_1              (rs2_1),
		.rd_1               (rd_1),
		.op_1               (op_1),
		.is_load_1          (is_load_1),
		.is_store_1         (is_store_1),
		.is_controlflow_1   (is_controlflow_1),
		.is_priv_1          (is_priv_1),
		.is_hilo_1          (is_hilo_1),
		.delayslot_not_exec (delayslot_not_exec),
		.ex_rd              (ex_rd),
		.ex_is_load         (ex_is_load),
		.ex_is_priv         (ex_is_priv),
		.dc_rd              (dc_rd),
		.dc_is_load         (dc_is_load),
		.dc_is_priv         (dc_is_priv),
		.issue_num          (issue_num),
		.stall_req          (stall_req),
		.issue_op0          (issue_op0),
		.issue_op1          (issue_op1),
		.issue_rd           (issue_rd),
		.issue_is_load      (issue_is_load),
		.issue_is_priv      (issue_is_priv)
	);

	pipe_tracker #(
		.DCACHE_PIPE_DEPTH (DCACHE_PIPE_DEPTH)
	) u_tracker (
		.clk           (clk),
		.arst_n        (arst_n),
		.stall_req     (stall_req),
		.issue_rd      (issue_rd),
		.issue_is_load (issue_is_load),
		.issue_is_priv (issue_is_priv),
		.ex_rd         (ex_rd),
		.ex_is_load    (ex_is_load),
		.ex_is_priv    (ex_is_priv),
		.dc_rd         (dc_rd),
		.dc_is_load    (dc_is_load),
		.dc_is_priv    (dc_is_priv)
	);

endmodule

`default_nettype wire

// File: hdl/pipe_tracker.sv
`default_nettype none

module pipe_tracker import issue_pkg::*; #(
	parameter int DCACHE_PIPE_DEPTH = 3
) (
	input  logic                                                   clk,
	input  logic                                                   arst_n,
	input  logic                                                   stall_req,
	input  logic [ISSUE_NUM-1:0][REG_W-1:0]                        issue_rd,
	input  logic [ISSUE_NUM-1:0]                                   issue_is_load,
	input  logic [ISSUE_NUM-1:0]                                   issue_is_priv,
	output logic [ISSUE_NUM-1:0][REG_W-1:0]                        ex_rd,
	output logic [ISSUE_NUM-1:0]                                   ex_is_load,
	output logic [ISSUE_NUM-1:0]                                   ex_is_priv,
	output logic [DCACHE_PIPE_DEPTH-1:0][ISSUE_NUM-1:0][REG_W-1:0] dc_rd,
	output logic [DCACHE_PIPE_DEPTH-1:0][ISSUE_NUM-1:0]            dc_is_load,
	output logic [DCACHE_PIPE_DEPTH-1:0][ISSUE_NUM-1:0]            dc_is_priv
);

	// ex stage, a stalled cycle enters as a bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_rd      <= '0;
			ex_is_load <= '0;
			ex_is_priv <= '0;
		end else if (stall_req) begin
			ex_rd      <= '0;
			ex_is_load <= '0;
			ex_is_priv <= '0;
		end else begin
			ex_rd      <= issue_rd;
			ex_is_load <= issue_is_load;
			ex_is_priv <= issue_is_priv;
		end
	end

	// dcache stages never hold, they drain behind a stall
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dc_rd      <= '0;
			dc_is_load <= '0;
			dc_is_priv <= '0;
		end else begin
			dc_rd[0]      <= ex_rd;
			dc_is_load[0] <= ex_is_load;
			dc_is_priv[0] <= ex_is_priv;
			for (int k = 1; k < DCACHE_PIPE_DEPTH; k++) begin
				dc_rd[k]      <= dc_rd[k-1];
				dc_is_load[k] <= dc_is_load[k-1];
				dc_is_priv[k] <= dc_is_priv[k-1];
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/instr_issue.sv
`default_nettype none

module instr_issue import issue_pkg::*; #(
	parameter int DCACHE_PIPE_DEPTH = 3
) (
	input  logic [ISSUE_NUM-1:0]                            fetch_valid,
	input  logic [REG_W-1:0]                                rs1_0,
	input  logic [REG_W-1:0]                                rs2_0,
	input  logic [REG_W-1:0]                                rd_0,
	input  op_t                                             op_0,
	input  logic                                            is_load_0,
	input  logic                                            is_store_0,
	input  logic                                            is_controlflow_0,
	input  logic                                            is_priv_0,
	input  logic                                            is_hilo_0,
	input  logic [REG_W-1:0]                                rs1_1,
	input  logic [REG_W-1:0]                                rs2_1,
	input  logic [REG_W-1:0]                                rd_1,
	input  op_t                                             op_1,
	input  logic                                            is_load_1,
	input  logic                                            is_store_1,
	input  logic                                            is_controlflow_1,
	input  logic                                            is_priv_1,
	input  logic                                            is_hilo_1,
	input  logic                                            delayslot_not_exec,
	input  logic [ISSUE_NUM-1:0][REG_W-1:0]                 ex_rd,
	input  logic [ISSUE_NUM-1:0]                            ex_is_load,
	input  logic [ISSUE_NUM-1:0]                            ex_is_priv,
	input  logic [DCACHE_PIPE_DEPTH-1:0][ISSUE_NUM-1:0][REG_W-1:0] dc_rd,
	input  logic [DCACHE_PIPE_DEPTH-1:0][ISSUE_NUM-1:0]     dc_is_load,
	input  logic [DCACHE_PIPE_DEPTH-1:0][ISSUE_NUM-1:0]     dc_is_priv,
	output logic [$clog2(ISSUE_NUM+1)-1:0]                  issue_num,
	output logic                                            stall_req,
	output op_t                                             issue_op0,
	output op_t                                             issue_op1,
	output logic [ISSUE_NUM-1:0][REG_W-1:0]                 issue_rd,
	output logic [ISSUE_NUM-1:0]                            issue_is_load,
	output logic [ISSUE_NUM-1:0]                            issue_is_priv
);

	localparam int CNT_W = $clog2(ISSUE_NUM + 1);

	logic [ISSUE_NUM-1:0][REG_W-1:0] id_rs1;
	logic [ISSUE_NUM-1:0][REG_W-1:0] id_rs2;
	logic [ISSUE_NUM-1:0]            id_store;
	logic [ISSUE_NUM-1:0]            load_hit;
	logic                            priv_inflight;
	logic                            raw_pair;
	logic                            drop1;

	// src2_ok low masks out store data, which can still be forwarded late
	function automatic logic load_dep(
		input logic [REG_W-1:0] src1,
		input logic [REG_W-1:0] src2,
		input logic             src2_ok,
		input logic [REG_W-1:0] dst,
		input logic             dst_load
	);
		return dst_load && dst != '0 && (src1 == dst || (src2_ok && src2 == dst));
	endfunction

	assign id_rs1   = {rs1_1, rs1_0};
	assign id_rs2   = {rs2_1, rs2_0};
	assign id_store = {is_store_1, is_store_0};

	always_comb begin
		load_hit = '0;
		for (int i = 0; i < ISSUE_NUM; i++) begin
			for (int j = 0; j < ISSUE_NUM; j++) begin
				load_hit[i] |= load_dep(id_rs1[i], id_rs2[i], 1'b1, ex_rd[j], ex_is_load[j]);
				load_hit[i] |= load_dep(id_rs1[i], id_rs2[i], 1'b1,
					dc_rd[0][j], dc_is_load[0][j]);
				// last stage forwards everything
				for (int k = 1; k < DCACHE_PIPE_DEPTH - 1; k++) begin
					load_hit[i] |= load_dep(id_rs1[i], id_rs2[i], ~id_store[i],
						dc_rd[k][j], dc_is_load[k][j]);
				end
			end
		end
		load_hit &= fetch_valid;
	end

	assign priv_inflight = (|ex_is_priv) | (|dc_is_priv);

	assign raw_pair = rd_0 != '0 && (rs1_1 == rd_0 || rs2_1 == rd_0);

	assign drop1 =
		  ~fetch_valid[1]
		| raw_pair
		| ((is_load_0 | is_store_0) & (is_load_1 | is_store_1))
		| (is_hilo_0 & is_hilo_1)
		| delayslot_not_exec
		// branches only go down slot 0
		| is_controlflow_1
		| (op_0 == OP_SSNOP) | (op_1 == OP_SSNOP)
		| (op_0 == OP_SC) | (op_1 == OP_SC)
		| is_priv_0 | is_priv_1
		| (op_1 == OP_DIV) | (op_1 == OP_DIVU);

	// priv instructions run alone, wait for the pipe to drain
	assign stall_req =
		  load_hit[0]
		| (load_hit[1] & ~drop1)
		| priv_inflight
		| (is_controlflow_0 & ~fetch_valid[1])
		| (fetch_valid == '0);

	assign issue_num = drop1 ? CNT_W'(ISSUE_NUM - 1) : CNT_W'(ISSUE_NUM);

	assign issue_op0        = op_0;
	assign issue_op1        = drop1 ? OP_NONE : op_1;
	assign issue_rd[0]      = rd_0;
	assign issue_rd[1]      = drop1 ? '0 : rd_1;
	assign issue_is_load[0] = is_load_0;
	assign issue_is_load[1] = is_load_1 & ~drop1;
	assign issue_is_priv[0] = is_priv_0;
	assign issue_is_priv[1] = is_priv_1 & ~drop1;

endmodule

`default_nettype wire

// File: hdl/instr_decoder.sv
`default_nettype none

module instr_decoder import issue_pkg::*; (
	input  logic [31:0]      instr,
	input  logic             valid,
	output logic [REG_W-1:0] rs1,
	output logic [REG_W-1:0] rs2,
	output logic [REG_W-1:0] rd,
	output op_t              op,
	output logic             is_load,
	output logic             is_store,
	output logic             is_controlflow,
	output logic             is_priv,
	output logic             is_hilo
);

	logic [5:0]       primary;
	logic [5:0]       funct;
	logic [REG_W-1:0] f_rs;
	logic [REG_W-1:0] f_rt;
	logic [REG_W-1:0] f_rd;

	assign primary = instr[31:26];
	assign funct   = instr[5:0];
	assign f_rs    = instr[25:21];
	assign f_rt    = instr[20:16];
	assign f_rd    = instr[15:11];

	always_comb begin
		rs1            = '0;
		rs2            = '0;
		rd             = '0;
		op             = OP_NONE;
		is_load        = 1'b0;
		is_store       = 1'b0;
		is_controlflow = 1'b0;
		is_priv        = 1'b0;
		is_hilo        = 1'b0;
		if (valid) begin
			case (primary) inside
				6'b000000: begin
					rs1 = f_rs;
					rs2 = f_rt;
					rd  = f_rd;
					op  = OP_ALU;
					if (instr == 32'h0000_0040) begin
						// ssnop, sll r0,r0,1
						rs1 = '0;
						rs2 = '0;
						rd  = '0;
						op  = OP_SSNOP;
					end else if (funct[5:1] == 5'b00100) begin
						// jr / jalr, only jalr links
						rs2            = '0;
						op             = OP_BRANCH;
						is_controlflow = 1'b1;
						if (!funct[0]) begin
							rd = '0;
						end
					end else if (funct[5:4] == 2'b01 && !funct[2]) begin
						is_hilo = 1'b1;
						op      = OP_MULDIV;
						if (!funct[3]) begin
							// mfhi/mflo write rd, mthi/mtlo read rs
							rs2 = '0;
							if (funct[0]) begin
								rd = '0;
							end else begin
								rs1 = '0;
							end
						end else begin
							rd = '0;
							if (funct[1]) begin
								op = funct[0] ? OP_DIVU : OP_DIV;
							end
						end
					end
				end
				6'b011100: begin
					rs1 = f_rs;
					rs2 = f_rt;
					rd  = f_rd;
					op  = OP_ALU;
					// madd, maddu, msub, msubu
					if (funct[5:3] == 3'b000 && !funct[1]) begin
						rd      = '0;
						op      = OP_MULDIV;
						is_hilo = 1'b1;
					end
				end
				6'b000001: begin
					// regimm, the *al forms link r31
					rs1            = f_rs;
					rd             = instr[20] ? REG_W'(31) : '0;
					op             = OP_BRANCH;
					is_controlflow = 1'b1;
				end
				6'b00001?: begin
					rd             = primary[0] ? REG_W'(31) : '0;
					op             = OP_BRANCH;
					is_controlflow = 1'b1;
				end
				6'b0001??, 6'b0101??: begin
					rs1            = f_rs;
					rs2            = f_rt;
					op             = OP_BRANCH;
					is_controlflow = 1'b1;
				end
				6'b001???: begin
					rs1 = f_rs;
					rd  = f_rt;
					op  = OP_ALU;
				end
				6'b010000: begin
					op      = OP_PRIV;
					is_priv = 1'b1;
					// mfc0 writes rt, mtc0 reads it
					if (f_rs == 5'b00000) begin
						rd = f_rt;
					end else if (f_rs == 5'b00100) begin
						rs2 = f_rt;
					end
				end
				6'b100???, 6'b110000: begin
					rs1     = f_rs;
					rd      = f_rt;
					op      = OP_LOAD;
					is_load = 1'b1;
				end
				6'b101???: begin
					// rs2 carries the store data
					rs1      = f_rs;
					rs2      = f_rt;
					op       = OP_STORE;
					is_store = 1'b1;
				end
				6'b111000: begin
					// sc returns its success flag in rt
					rs1      = f_rs;
					rs2      = f_rt;
					rd       = f_rt;
					op       = OP_SC;
					is_store = 1'b1;
				end
				default: begin
					op = OP_ALU;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/issue_pkg.sv
`default_nettype none

package issue_pkg;

	// two slots only, the pairing rules assume a pair
	localparam int ISSUE_NUM = 2;

	// architectural register index
	localparam int REG_W = 5;

	// opcode classes seen by the issue logic
	typedef enum logic [3:0] {
		OP_NONE   = 4'd0,
		OP_ALU    = 4'd1,
		OP_LOAD   = 4'd2,
		OP_STORE  = 4'd3,
		// branches and jumps
		OP_BRANCH = 4'd4,
		// mult, madd family and hi/lo moves
		OP_MULDIV = 4'd5,
		OP_DIV    = 4'd6,
		OP_DIVU   = 4'd7,
		OP_SC     = 4'd8,
		// cop0 accesses
		OP_PRIV   = 4'd9,
		OP_SSNOP  = 4'd10
	} op_t;

endpackage

`default_nettype wire
